//--- dv/lsu_tb.sv
// self-checking testbench for lsu_top with a byte-array memory model, run as the simulation top
`timescale 1ns/1ns
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int N_WORD       = 16;
    localparam int REGION_WORDS = 16;
    localparam int N_PAIRS      = 60;
    localparam int N_REQ        = 2 * N_WORD + 18 + 26 + 14 + REGION_WORDS + 2 * N_PAIRS;
    localparam int IDLE_CYCLES  = RESET_CYCLES + 4 + 6 * 5;  // reset, then a drain per test
    localparam int MAX_CYCLES   = N_REQ + IDLE_CYCLES + 50;

    logic              clk = 1'b0;
    logic              resetn;
    logic              req;
    mem_op_t           req_op;
    logic [WORD_W-1:0] base;
    logic [WORD_W-1:0] offset;
    logic [WORD_W-1:0] store_data;
    logic              done;
    logic [WORD_W-1:0] load_data;
    logic              load_fault;
    logic              store_fault;

    logic [7:0]  ref_mem [1024];  // byte-addressed model of the data RAM
    logic [9:0]  word_addr [N_WORD];
    int          exp_cyc_q [$];
    logic [31:0] exp_data_q [$];
    logic        exp_lf_q [$];
    logic        exp_sf_q [$];
    int          seed   = 31113;
    int          cyc    = 0;
    int          checks = 0;
    int          errors = 0;
    logic        req_d1 = 1'b0;
    logic        req_d2 = 1'b0;

    lsu_top u_dut (
        .clk(clk), .resetn(resetn), .req(req), .req_op(req_op), .base(base),
        .offset(offset), .store_data(store_data), .done(done), .load_data(load_data),
        .load_fault(load_fault), .store_fault(store_fault)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int access_bytes(mem_op_t op);
        case (op)
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_SW:         return 4;
            default:              return 1;
        endcase
    endfunction

    function automatic logic is_store(mem_op_t op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // one request on the next rising edge, its expected response goes on the queues
    task automatic issue(input mem_op_t op, input logic [9:0] addr, input logic [31:0] data);
        int          nb;
        logic        bad;
        logic [31:0] value;
        logic [31:0] r;
        logic [31:0] ofs;
        nb    = access_bytes(op);
        bad   = (addr % nb) != 0;
        value = '0;
        r     = $random(seed);
        ofs   = {{16{r[15]}}, r[15:0]};
        r     = $random(seed);
        if (!bad && is_store(op)) begin
            for (int i = 0; i < nb; i++) begin
                ref_mem[(int'(addr) + i) % 1024] = data[8*i +: 8];
            end
        end else if (!bad) begin
            for (int i = nb - 1; i >= 0; i--) begin
                value = {value[23:0], ref_mem[(int'(addr) + i) % 1024]};
            end
            if (op == OP_LB && value[7]) value[31:8] = '1;
            if (op == OP_LH && value[15]) value[31:16] = '1;
        end
        @(posedge clk);
        req        <= 1'b1;
        req_op     <= op;
        base       <= (r & 32'hFFFF_FC00) + {22'b0, addr} - ofs;  // upper bits must not matter
        offset     <= ofs;
        store_data <= data;
        exp_cyc_q.push_back(cyc + 3);
        exp_data_q.push_back(value);
        exp_lf_q.push_back(bad && !is_store(op));
        exp_sf_q.push_back(bad && is_store(op));
    endtask

    task automatic finish_burst();
        @(posedge clk);
        req    <= 1'b0;
        req_op <= OP_NONE;
        while (exp_cyc_q.size() != 0) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-16s %s, %0d errors", name,
                 (errors == err_before) ? "passed" : "failed", errors - err_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response checks, sampled on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!resetn) begin
            check_value("done", 32'd0, {31'b0, done});
            check_value("load_fault", 32'd0, {31'b0, load_fault});
            check_value("store_fault", 32'd0, {31'b0, store_fault});
        end else begin
            check_value("done", {31'b0, req_d2}, {31'b0, done});  // two cycles after req
            if (done && exp_cyc_q.size() == 0) begin
                $display("done at %0t with no request outstanding", $time);
                errors++;
            end else if (done) begin
                check_value("done cycle", exp_cyc_q.pop_front(), cyc);
                check_value("load_data", exp_data_q.pop_front(), load_data);
                check_value("load_fault", {31'b0, exp_lf_q.pop_front()}, {31'b0, load_fault});
                check_value("store_fault", {31'b0, exp_sf_q.pop_front()}, {31'b0, store_fault});
            end else begin
                check_value("load_fault", 32'd0, {31'b0, load_fault});
                check_value("store_fault", 32'd0, {31'b0, store_fault});
            end
        end
        req_d2 = req_d1;
        req_d1 = req;
    end

    initial begin
        while (cyc < MAX_CYCLES) @(posedge clk);
        $display("timeout: run went past %0d cycles", MAX_CYCLES);
        $display("Errors found");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          err0;
        logic [31:0] r;
        logic [31:0] w;
        logic [9:0]  a;
        mem_op_t     op;
        resetn     = 1'b0;
        req        = 1'b0;
        req_op     = OP_NONE;
        base       = '0;
        offset     = '0;
        store_data = '0;

        err0 = errors;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        repeat (4) @(posedge clk);
        report_test("reset", err0);

        err0 = errors;
        for (int i = 0; i < N_WORD; i++) begin
            r = $random(seed);
            word_addr[i] = r[9:0] & 10'h3FC;
            issue(OP_SW, word_addr[i], $random(seed));
        end
        for (int i = 0; i < N_WORD; i++) issue(OP_LW, word_addr[i], $random(seed));
        finish_burst();
        report_test("word_store_load", err0);

        err0 = errors;
        for (int l = 0; l < 4; l++) begin
            issue(OP_SW, 10'h200, $random(seed));
            issue(OP_SB, 10'h200 | l[1:0], $random(seed));
            issue(OP_LW, 10'h200, 0);
        end
        for (int l = 0; l < 4; l += 2) begin
            issue(OP_SW, 10'h200, $random(seed));
            issue(OP_SH, 10'h200 | l[1:0], $random(seed));
            issue(OP_LW, 10'h200, 0);
        end
        finish_burst();
        report_test("narrow_stores", err0);

        err0 = errors;
        for (int k = 0; k < 2; k++) begin
            w = $random(seed);
            w = (k == 0) ? (w | 32'h8080_8080) : (w & 32'h7F7F_7F7F);  // negative, then positive
            issue(OP_SW, 10'h240, w);
            for (int l = 0; l < 4; l++) begin
                issue(OP_LB, 10'h240 | l[1:0], 0);
                issue(OP_LBU, 10'h240 | l[1:0], 0);
            end
            for (int l = 0; l < 4; l += 2) begin
                issue(OP_LH, 10'h240 | l[1:0], 0);
                issue(OP_LHU, 10'h240 | l[1:0], 0);
            end
        end
        finish_burst();
        report_test("narrow_loads", err0);

        err0 = errors;
        issue(OP_SW, 10'h280, $random(seed));
        for (int l = 1; l < 4; l += 2) begin
            issue(OP_LH, 10'h280 | l[1:0], 0);
            issue(OP_LHU, 10'h280 | l[1:0], 0);
        end
        for (int l = 1; l < 4; l++) issue(OP_LW, 10'h280 | l[1:0], 0);
        for (int l = 1; l < 4; l += 2) issue(OP_SH, 10'h280 | l[1:0], $random(seed));
        for (int l = 1; l < 4; l++) issue(OP_SW, 10'h280 | l[1:0], $random(seed));
        issue(OP_LW, 10'h280, 0);  // the word must be untouched
        finish_burst();
        report_test("misalignment", err0);

        err0 = errors;
        for (int i = 0; i < REGION_WORDS; i++) issue(OP_SW, 10'h100 + 10'(4 * i), $random(seed));
        for (int i = 0; i < N_PAIRS; i++) begin
            r  = $random(seed);
            op = mem_op_t'(4'd1 + {1'b0, r[2:0]});
            a  = {4'b0100, r[7:4], r[9:8]};  // 16 words from 0x100, any lane
            issue(op, a, $random(seed));
            if (is_store(op)) begin
                issue(OP_LW, a & 10'h3FC, 0);  // load of the word just written
            end else begin
                r = $random(seed);
                issue(mem_op_t'(4'd1 + {1'b0, r[2:0]}), {4'b0100, r[7:4], r[9:8]}, $random(seed));
            end
        end
        finish_burst();
        report_test("back_to_back", err0);

        $display("checks passed %0d, errors %0d", checks - errors, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/lsu_pkg.sv
rtl/lsu_ctrl.sv
rtl/agu.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/data_ram.sv
rtl/lsu_top.sv
dv/lsu_tb.sv

//--- rtl/agu.sv
// address generation: base plus offset, registered byte address and alignment check
`timescale 1ns/1ns
`default_nettype none

module agu
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              req,
    input  logic [WORD_W-1:0] base,
    input  logic [WORD_W-1:0] offset,
    input  mem_op_t           s1_op,
    output logic [ADDR_W-1:0] addr,
    output logic              misaligned,
    output logic [1:0]        s2_lane
);

    logic [WORD_W-1:0] sum;

    assign sum = base + offset;  // only the low ADDR_W bits are kept, so addresses wrap

    always_ff @(posedge clk) begin
        if (!resetn) begin
            addr    <= '0;
            s2_lane <= 2'b00;
        end else begin
            if (req) begin
                addr <= sum[ADDR_W-1:0];
            end
            s2_lane <= addr[1:0];  // follows the access into stage 2 for load extraction
        end
    end

    // the size comes from the opcode that ctrl holds in stage 1
    always_comb begin
        case (op_size(s1_op))
            SZ_HALF: misaligned = addr[0];
            SZ_WORD: misaligned = |addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/data_ram.sv
// on-chip data memory, one word per entry, byte-enabled writes and one-cycle registered reads
`timescale 1ns/1ns
`default_nettype none

module data_ram
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              we,
    input  logic              re,
    input  logic [RAM_AW-1:0] waddr_word,
    input  logic [3:0]        byte_en,
    input  logic [WORD_W-1:0] wdata,
    output logic [WORD_W-1:0] rdata
);

    logic [WORD_W-1:0] mem [RAM_DEPTH];

    // write port, one enable per byte lane
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[waddr_word][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // read port, rdata holds between reads
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[waddr_word];
        end
    end

endmodule

`default_nettype wire

//--- rtl/load_align.sv
// load extraction: picks the addressed byte or halfword of the RAM word and extends it
`timescale 1ns/1ns
`default_nettype none

module load_align
    import lsu_pkg::*;
(
    input  mem_op_t           s2_op,
    input  logic [1:0]        lane,
    input  logic              s2_fault,
    input  logic [WORD_W-1:0] rdata,
    output logic [WORD_W-1:0] load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        sign_ext;

    assign sel_byte = rdata[{lane, 3'b000} +: 8];
    assign sel_half = lane[1] ? rdata[31:16] : rdata[15:0];  // lane[0] is zero when aligned
    assign sign_ext = (s2_op == OP_LB) || (s2_op == OP_LH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // extension and zeroing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        load_data = '0;  // stores, idle slots and faulting loads return zero
        if (!s2_fault && op_is_load(s2_op)) begin
            case (op_size(s2_op))
                SZ_BYTE: begin
                    load_data = {{(WORD_W-8){sign_ext & sel_byte[7]}}, sel_byte};
                end
                SZ_HALF: begin
                    load_data = {{(WORD_W-16){sign_ext & sel_half[15]}}, sel_half};
                end
                default: begin
                    load_data = rdata;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_ctrl.sv
// two-stage valid/opcode pipeline that gates RAM access, records faults and issues done
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              req,
    input  mem_op_t           req_op,
    input  logic [WORD_W-1:0] store_data,
    input  logic              misaligned,
    output mem_op_t           s1_op,
    output mem_op_t           s2_op,
    output logic              ram_we,
    output logic              ram_re,
    output logic [WORD_W-1:0] s1_store_data,
    output logic              s2_fault,
    output logic              done,
    output logic              load_fault,
    output logic              store_fault
);

    logic s1_valid;
    logic s2_valid;
    logic s1_store;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            s1_op    <= OP_NONE;
        end else begin
            s1_valid <= req;
            s1_op    <= req ? req_op : OP_NONE;  // idle slots carry no opcode
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            s1_store_data <= store_data;
        end
    end

    assign s1_store = s1_op inside {OP_SB, OP_SH, OP_SW};

    // a misaligned access touches neither port of the RAM
    assign ram_we = s1_valid && s1_store && !misaligned;
    assign ram_re = s1_valid && op_is_load(s1_op) && !misaligned;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!resetn) begin
            s2_valid <= 1'b0;
            s2_op    <= OP_NONE;
            s2_fault <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_op    <= s1_op;
            s2_fault <= s1_valid && misaligned;
        end
    end

    assign done        = s2_valid;  // two clocks after the request edge
    assign load_fault  = s2_valid && s2_fault && op_is_load(s2_op);
    assign store_fault = s2_valid && s2_fault && !op_is_load(s2_op);

endmodule

`default_nettype wire

//--- rtl/lsu_pkg.sv
// shared opcodes, widths and access-size helpers, imported by every LSU module and the testbench
`default_nettype none

package lsu_pkg;

    localparam int WORD_W    = 32;
    localparam int ADDR_W    = 10;          // byte address kept by the unit, wraps at 1 KiB
    localparam int RAM_DEPTH = 256;
    localparam int RAM_AW    = ADDR_W - 2;  // word index into the data RAM

    // access sizes as returned by op_size
    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_t;

    function automatic logic op_is_load(mem_op_t op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic [1:0] op_size(mem_op_t op);
        logic [1:0] size;
        case (op)
            OP_LH, OP_LHU, OP_SH: size = SZ_HALF;
            OP_LW, OP_SW:         size = SZ_WORD;
            default:              size = SZ_BYTE;  // bytes and the idle opcode never fault
        endcase
        return size;
    endfunction

endpackage

`default_nettype wire

//--- rtl/lsu_top.sv
// memory-access stage top level: request in, done with load data and faults two cycles later
`timescale 1ns/1ns
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              req,
    input  mem_op_t           req_op,
    input  logic [WORD_W-1:0] base,
    input  logic [WORD_W-1:0] offset,
    input  logic [WORD_W-1:0] store_data,
    output logic              done,
    output logic [WORD_W-1:0] load_data,
    output logic              load_fault,
    output logic              store_fault
);

    mem_op_t           s1_op;
    mem_op_t           s2_op;
    logic              ram_we;
    logic              ram_re;
    logic [WORD_W-1:0] s1_store_data;
    logic              s2_fault;
    logic [ADDR_W-1:0] addr;
    logic              misaligned;
    logic [1:0]        s2_lane;
    logic [RAM_AW-1:0] ram_word;
    logic [WORD_W-1:0] wdata;
    logic [WORD_W-1:0] rdata;
    logic [3:0]        byte_en;

    assign ram_word = addr[ADDR_W-1 -: RAM_AW];  // drop the two lane bits

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and address
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    lsu_ctrl u_ctrl (
        .clk(clk), .resetn(resetn), .req(req), .req_op(req_op),
        .store_data(store_data), .misaligned(misaligned),
        .s1_op(s1_op), .s2_op(s2_op), .ram_we(ram_we), .ram_re(ram_re),
        .s1_store_data(s1_store_data), .s2_fault(s2_fault),
        .done(done), .load_fault(load_fault), .store_fault(store_fault)
    );

    agu u_agu (
        .clk(clk), .resetn(resetn), .req(req), .base(base), .offset(offset),
        .s1_op(s1_op), .addr(addr), .misaligned(misaligned), .s2_lane(s2_lane)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    store_align u_store_align (
        .s1_op(s1_op), .lane(addr[1:0]), .store_data(s1_store_data),
        .wdata(wdata), .byte_en(byte_en)
    );

    data_ram u_data_ram (
        .clk(clk), .we(ram_we), .re(ram_re), .waddr_word(ram_word),
        .byte_en(byte_en), .wdata(wdata), .rdata(rdata)
    );

    load_align u_load_align (
        .s2_op(s2_op), .lane(s2_lane), .s2_fault(s2_fault), .rdata(rdata),
        .load_data(load_data)
    );

endmodule

`default_nettype wire

//--- rtl/store_align.sv
// store lane shifter: moves store data onto the byte lanes and forms the RAM byte enables
`timescale 1ns/1ns
`default_nettype none

module store_align
    import lsu_pkg::*;
(
    input  mem_op_t           s1_op,
    input  logic [1:0]        lane,
    input  logic [WORD_W-1:0] store_data,
    output logic [WORD_W-1:0] wdata,
    output logic [3:0]        byte_en
);

    logic [7:0]  st_byte;
    logic [15:0] st_half;

    assign st_byte = store_data[7:0];
    assign st_half = store_data[15:0];

    // narrow data is replicated on every lane, the enables pick the one that lands
    always_comb begin
        wdata   = '0;
        byte_en = 4'b0000;
        case (s1_op)
            OP_SW: begin
                wdata   = store_data;
                byte_en = 4'b1111;
            end
            OP_SH: begin
                wdata   = {2{st_half}};
                byte_en = lane[1] ? 4'b1100 : 4'b0011;
            end
            OP_SB: begin
                wdata   = {4{st_byte}};
                byte_en = 4'b0001 << lane;
            end
            default: begin
                wdata   = '0;  // loads and idle slots write nothing
                byte_en = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire
